// File: proc.f
source/procPkg.sv
source/procIf.sv
source/fetch.sv
source/decode.sv
source/execute.sv
source/memory.sv
source/proc.sv
verif/procChecker.sv
verif/procMonitor.sv
verif/procTb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module procTb \
   -f proc.f -o procSim > build.log 2>&1 \
   && { ./obj_dir/procSim || echo "Test failures found"; } > sim.log 2>&1 \
   || echo "Test failures found" >> sim.log
cat build.log sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

// File: verif/procTb.sv
// Testbench for the processor core with random programs and a Wishbone slave memory
module procTb import procPkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int progLen = 200;
   localparam int loadCycles = progLen + 8;
   localparam int timeLimitNs = 2 * (loadCycles + progLen * 5) * 10 + 2000;
   localparam logic [31:0] seed = 32'h1f3b658c;

   logic clk;
   logic reset;
   logic imemWe;
   logic [imemAddrWidth-1:0] imemAddr;
   logic [dataWidth-1:0] imemData;
   logic wbCyc;
   logic wbStb;
   logic wbWe;
   logic [dataWidth-1:0] wbAdr;
   logic [dataWidth-1:0] wbDatO;
   logic [dataWidth-1:0] wbDatI;
   logic wbAck;
   logic halted;
   logic err;
   logic [dataWidth-1:0] prog [imemDepth];
   logic [dataWidth-1:0] dmem [dmemDepth];
   logic [dataWidth-1:0] memInit [dmemDepth];
   logic [31:0] lfsr;
   int waitLeft;
   int monErrors;
   int chkErrors;

   function automatic logic [31:0] nextLfsr(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] takeBits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = nextLfsr(lfsr);
         bits = {bits[30:0], lfsr[0]};
      end
      return bits;
   endfunction

   always #5 clk = ~clk;

   proc i_proc (.clk(clk), .reset(reset), .imemWe(imemWe), .imemAddr(imemAddr),
      .imemData(imemData), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
      .wbDatO(wbDatO), .wbDatI(wbDatI), .wbAck(wbAck), .halted(halted), .err(err));

   procMonitor i_monitor (.clk(clk), .reset(reset), .wbCyc(wbCyc), .wbStb(wbStb),
      .wbWe(wbWe), .wbAdr(wbAdr), .wbDatO(wbDatO), .wbAck(wbAck), .halted(halted),
      .err(err), .prog(prog), .memInit(memInit), .errCount(monErrors));

   bind proc procChecker i_checker (.*);

   assign chkErrors = i_proc.i_checker.failCount;

   // Slave memory, acks after 0 to 3 random wait cycles
   always @(negedge clk) begin
      if (reset || wbAck) begin
         wbAck = 1'b0;
      end else if (wbCyc && wbStb) begin
         if (waitLeft == 0) begin
            wbAck = 1'b1;
            if (wbWe) dmem[wbAdr[7:0]] = wbDatO;
            else wbDatI = dmem[wbAdr[7:0]];
            waitLeft = takeBits(2);
         end else begin
            waitLeft--;
         end
      end
   end

   task automatic genProgram(input bit illegalTest);
      logic [31:0] r;
      int k;
      int d;
      for (int i = 0; i < dmemDepth; i++) begin
         r = takeBits(16);
         dmem[i] = r[15:0];
         memInit[i] = r[15:0];
      end
      for (int i = 0; i < imemDepth; i++) begin
         prog[i] = {opHalt, 11'd0};
      end
      for (int i = 0; i < 8; i++) begin
         r = takeBits(8);
         prog[i] = {opLbi, 3'(i), r[7:0]};
      end
      if (illegalTest) begin
         prog[8] = {opSt, 3'd1, 3'd2, 5'd3};
         prog[9] = {opSt, 3'd3, 3'd4, 5'd0};
         prog[10] = {5'b11111, 11'd0};
         prog[11] = {opSt, 3'd0, 3'd0, 5'd0};
      end else begin
         for (int i = 8; i <= 190; i++) begin
            r = takeBits(16);
            k = takeBits(4);
            d = takeBits(3);
            // Forward only, never past the register dump
            if (d > 190 - i) d = 190 - i;
            case (k)
               4: prog[i] = {opAddi, r[10:0]};
               5: prog[i] = {opSubi, r[10:0]};
               6: prog[i] = {opLbi, r[10:0]};
               7, 8: prog[i] = {opLd, r[10:0]};
               9, 10: prog[i] = {opSt, r[10:0]};
               11: prog[i] = {opBeqz, r[10:8], 8'(d)};
               12: prog[i] = {opBnez, r[10:8], 8'(d)};
               13: prog[i] = {opJ, 11'(d)};
               default: prog[i] = {opAlu, r[10:0]};
            endcase
         end
         for (int i = 191; i < 199; i++) begin
            prog[i] = {opSt, 3'd0, 3'(i - 191), 5'(i - 191)};
         end
      end
   endtask

   task automatic runProgram(input bit illegalTest);
      genProgram(illegalTest);
      @(negedge clk);
      i_monitor.buildModel();
      reset = 1'b1;
      for (int a = 0; a < progLen; a++) begin
         imemWe = 1'b1;
         imemAddr = 8'(a);
         imemData = prog[a];
         @(negedge clk);
      end
      imemWe = 1'b0;
      repeat (8) @(negedge clk);
      reset = 1'b0;
      while (!halted) @(posedge clk);
      // Quiet window to catch stray bus cycles
      repeat (10) @(posedge clk);
      i_monitor.endCheck();
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      imemWe = 1'b0;
      imemAddr = '0;
      imemData = '0;
      wbDatI = '0;
      wbAck = 1'b0;
      lfsr = seed;
      waitLeft = 0;
      runProgram(1'b0);
      runProgram(1'b1);
      $display("closing: %0d monitor errors, %0d assertion failures", monErrors, chkErrors);
      if (monErrors == 0 && chkErrors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      #(timeLimitNs);
      $display("timeout: core did not halt");
      $display("closing: %0d monitor errors, %0d assertion failures, 1 timeout",
         monErrors, chkErrors);
      $display("Test failures found");
      $finish;
   end

endmodule

// File: verif/procMonitor.sv
// Instruction-set model that predicts bus accesses and compares them with the bus
module procMonitor import procPkg::*; (
   input  logic clk,
   input  logic reset,
   input  logic wbCyc,
   input  logic wbStb,
   input  logic wbWe,
   input  logic [dataWidth-1:0] wbAdr,
   input  logic [dataWidth-1:0] wbDatO,
   input  logic wbAck,
   input  logic halted,
   input  logic err,
   input  logic [dataWidth-1:0] prog [imemDepth],
   input  logic [dataWidth-1:0] memInit [dmemDepth],
   output int errCount
);
   timeunit 1ns;
   timeprecision 1ps;

   // Expected accesses in program order, loads and stores alike
   logic [dataWidth-1:0] expAdr [$];
   logic [dataWidth-1:0] expDat [$];
   bit expWe [$];
   logic [dataWidth-1:0] regs [numRegs];
   logic [dataWidth-1:0] mem [dmemDepth];
   logic [dataWidth-1:0] nextAdr;
   logic [dataWidth-1:0] nextDat;
   bit nextWe;
   bit expErr;
   bit haltSeen;
   int busErrors = 0;
   int endErrors = 0;

   assign errCount = busErrors + endErrors;

   // Runs the whole program ahead of the DUT and queues its accesses
   task automatic buildModel();
      logic [dataWidth-1:0] pc;
      logic [dataWidth-1:0] next;
      logic [dataWidth-1:0] instr;
      logic [dataWidth-1:0] addr;
      logic [dataWidth-1:0] imm5;
      logic [dataWidth-1:0] imm8;
      logic [dataWidth-1:0] disp;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      opcode_t op;
      bit done;
      int steps;
      expAdr.delete();
      expDat.delete();
      expWe.delete();
      expErr = 0;
      for (int i = 0; i < dmemDepth; i++) begin
         mem[i] = memInit[i];
      end
      pc = '0;
      done = 0;
      steps = 0;
      while (!done && steps < 2000) begin
         instr = prog[pc[8:1]];
         op = opcode_t'(instr[15:11]);
         rs = instr[10:8];
         rt = instr[7:5];
         rd = instr[4:2];
         imm5 = {{11{instr[4]}}, instr[4:0]};
         imm8 = {{8{instr[7]}}, instr[7:0]};
         disp = {{5{instr[10]}}, instr[10:0]};
         next = pc + 16'd2;
         case (op)
            opAlu: begin
               case (instr[1:0])
                  2'd0: regs[rd] = regs[rs] + regs[rt];
                  2'd1: regs[rd] = regs[rs] - regs[rt];
                  2'd2: regs[rd] = regs[rs] ^ regs[rt];
                  default: regs[rd] = regs[rs] & ~regs[rt];
               endcase
            end
            opAddi: regs[rt] = regs[rs] + imm5;
            opSubi: regs[rt] = regs[rs] - imm5;
            opLbi: regs[rs] = imm8;
            opLd: begin
               addr = regs[rs] + imm5;
               regs[rt] = mem[addr[7:0]];
               expAdr.push_back(addr);
               expDat.push_back(regs[rt]);
               expWe.push_back(1'b0);
            end
            opSt: begin
               addr = regs[rs] + imm5;
               expAdr.push_back(addr);
               expDat.push_back(regs[rt]);
               expWe.push_back(1'b1);
               mem[addr[7:0]] = regs[rt];
            end
            opBeqz: if (regs[rs] == 16'd0) next = next + {imm8[14:0], 1'b0};
            opBnez: if (regs[rs] != 16'd0) next = next + {imm8[14:0], 1'b0};
            opJ: next = next + {disp[14:0], 1'b0};
            opHalt: done = 1;
            default: begin
               done = 1;
               expErr = 1;
            end
         endcase
         pc = next;
         steps++;
      end
   endtask

   always @(posedge clk) begin
      if (reset) begin
         haltSeen <= 0;
      end else begin
         if (haltSeen && wbCyc) begin
            busErrors++;
            $display("bus cycle started after the core halted, at %0t", $time);
         end
         if (halted) haltSeen <= 1;
         if (wbCyc && wbStb && wbAck) begin
            if (expAdr.size() == 0) begin
               busErrors++;
               $display("bus access at %0t that the model never makes", $time);
            end else begin
               nextAdr = expAdr.pop_front();
               nextDat = expDat.pop_front();
               nextWe = expWe.pop_front();
               if (wbWe !== nextWe || wbAdr !== nextAdr ||
                     (nextWe && wbDatO !== nextDat)) begin
                  busErrors++;
                  $display("mismatch at %0t: got we %b adr %h data %h, expected %b %h %h",
                     $time, wbWe, wbAdr, wbDatO, nextWe, nextAdr, nextDat);
               end
            end
         end
      end
   end

   task automatic endCheck();
      if (expAdr.size() != 0) begin
         endErrors++;
         $display("%0d expected bus accesses never reached the bus", expAdr.size());
      end
      if (halted !== 1'b1) begin
         endErrors++;
         $display("core is not halted at the end of the program");
      end
      if (err !== expErr) begin
         endErrors++;
         $display("mismatch at %0t: err flag is %b, expected %b", $time, err, expErr);
      end
   endtask

endmodule

// File: verif/procChecker.sv
// Bus protocol and reset checker bound into the processor core
module procChecker import procPkg::*; (
   input logic clk,
   input logic reset,
   input logic wbCyc,
   input logic wbStb,
   input logic wbWe,
   input logic [dataWidth-1:0] wbAdr,
   input logic [dataWidth-1:0] wbDatO,
   input logic wbAck,
   input logic halted,
   input logic err
);
   timeunit 1ns;
   timeprecision 1ps;

   int failCount = 0;

   // Cycle closes on the edge after ack
   cycEndsAfterAck: assert property (@(posedge clk) disable iff (reset)
      (wbStb && wbAck) |=> (!wbCyc && !wbStb))
      else begin
         failCount++;
         $error("Wishbone cycle still open after ack");
      end

   // Request stays put until the slave acks it
   holdUntilAck: assert property (@(posedge clk) disable iff (reset)
      (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr) && $stable(wbDatO) && $stable(wbWe)))
      else begin
         failCount++;
         $error("Wishbone request changed or dropped before ack");
      end

   cleanAfterReset: assert property (@(posedge clk) $fell(reset) |-> (!err && !halted && !wbCyc))
      else begin
         failCount++;
         $error("err, halted or cyc high right after reset");
      end

endmodule

// File: source/proc.sv
// Processor core top level connecting fetch, decode, execute and memory stages
module proc import procPkg::*; (
   input  logic clk,
   input  logic reset,
   input  logic imemWe,
   input  logic [imemAddrWidth-1:0] imemAddr,
   input  logic [dataWidth-1:0] imemData,
   output logic wbCyc,
   output logic wbStb,
   output logic wbWe,
   output logic [dataWidth-1:0] wbAdr,
   output logic [dataWidth-1:0] wbDatO,
   input  logic [dataWidth-1:0] wbDatI,
   input  logic wbAck,
   output logic halted,
   output logic err
);

   fetchDecodeIf fdBus ();
   decodeExecIf deBus ();
   execMemIf emBus ();

   logic redirect;
   logic [dataWidth-1:0] target;
   logic stall;
   // Register file write port from the memory stage
   logic rfWe;
   logic [regAddrWidth-1:0] rfReg;
   logic [dataWidth-1:0] rfData;

   fetch i_fetch (.clk(clk), .reset(reset), .imemWe(imemWe), .imemAddr(imemAddr),
      .imemData(imemData), .redirect(redirect), .target(target), .stall(stall),
      .halt(halted), .fdOut(fdBus));

   decode i_decode (.clk(clk), .reset(reset), .fdIn(fdBus), .deOut(deBus),
      .wbWe(rfWe), .wbReg(rfReg), .wbData(rfData), .halt(halted), .err(err));

   execute i_execute (.deIn(deBus), .emOut(emBus), .redirect(redirect), .target(target));

   memory i_memory (.clk(clk), .reset(reset), .emIn(emBus), .busCyc(wbCyc),
      .busStb(wbStb), .busWe(wbWe), .busAdr(wbAdr), .busDatO(wbDatO), .busDatI(wbDatI),
      .busAck(wbAck), .stall(stall), .wbWe(rfWe), .wbReg(rfReg), .wbData(rfData));

endmodule

// File: source/memory.sv
// Memory stage with Wishbone classic master, stall and writeback select
module memory import procPkg::*; (
   input  logic clk,
   input  logic reset,
   execMemIf.sink emIn,
   output logic busCyc,
   output logic busStb,
   output logic busWe,
   output logic [dataWidth-1:0] busAdr,
   output logic [dataWidth-1:0] busDatO,
   input  logic [dataWidth-1:0] busDatI,
   input  logic busAck,
   output logic stall,
   output logic wbWe,
   output logic [regAddrWidth-1:0] wbReg,
   output logic [dataWidth-1:0] wbData
);

   typedef enum logic {idle, busy} memState_t;

   memState_t state;
   logic memReq;
   logic done;

   assign memReq = emIn.memRead | emIn.memWrite;
   assign done = (state == busy) & busAck;

   // One bus cycle per LD or ST, closed on the ack edge
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= idle;
      end else begin
         case (state)
            idle: if (memReq) state <= busy;
            busy: if (busAck) state <= idle;
            default: state <= idle;
         endcase
      end
   end

   assign busCyc = (state == busy);
   assign busStb = busCyc;
   assign busWe = busCyc & emIn.memWrite;
   // Word address straight from the ALU
   assign busAdr = emIn.aluResult;
   assign busDatO = emIn.storeData;

   // Instruction holds until its access is acked
   assign stall = memReq & !done;

   assign wbWe = emIn.regWrite & (!emIn.memRead | done);
   assign wbReg = emIn.dest;
   assign wbData = emIn.memRead ? busDatI : emIn.aluResult;

endmodule

// File: source/execute.sv
// Execute stage with ALU, zero test and branch target resolution
module execute import procPkg::*; (
   decodeExecIf.sink deIn,
   execMemIf.source emOut,
   output logic redirect,
   output logic [dataWidth-1:0] target
);

   logic [dataWidth-1:0] opB;
   logic [dataWidth-1:0] result;
   logic zeroA;

   assign opB = deIn.immSel ? deIn.imm : deIn.opB;

   always_comb begin
      case (deIn.aluOp)
         aluAdd: result = deIn.opA + opB;
         aluSub: result = deIn.opA - opB;
         aluXor: result = deIn.opA ^ opB;
         aluAndNot: result = deIn.opA & ~opB;
         default: result = deIn.opA;
      endcase
   end

   // Branches test Rs against zero
   assign zeroA = (deIn.opA == '0);

   always_comb begin
      case (deIn.brKind)
         brEqz: redirect = zeroA;
         brNez: redirect = !zeroA;
         brAlways: redirect = 1'b1;
         default: redirect = 1'b0;
      endcase
   end

   // Displacement counts instructions, so twice it in bytes
   assign target = deIn.pcPlus2 + {deIn.imm[dataWidth-2:0], 1'b0};

   assign emOut.aluResult = result;
   assign emOut.storeData = deIn.storeData;
   assign emOut.memRead = deIn.memRead;
   assign emOut.memWrite = deIn.memWrite;
   assign emOut.regWrite = deIn.regWrite;
   assign emOut.dest = deIn.dest;

endmodule

// File: source/decode.sv
// Decode stage with control table, register file and illegal-opcode trap
module decode import procPkg::*; (
   input  logic clk,
   input  logic reset,
   fetchDecodeIf.sink fdIn,
   decodeExecIf.source deOut,
   input  logic wbWe,
   input  logic [regAddrWidth-1:0] wbReg,
   input  logic [dataWidth-1:0] wbData,
   output logic halt,
   output logic err
);

   logic [dataWidth-1:0] regs [numRegs];
   opcode_t opcode;
   logic [regAddrWidth-1:0] rs;
   logic [regAddrWidth-1:0] rt;
   logic [regAddrWidth-1:0] rd;
   logic [dataWidth-1:0] imm5Ext;
   logic [dataWidth-1:0] imm8Ext;
   logic [dataWidth-1:0] disp11Ext;

   // Control bits before the valid gate
   aluOp_t aluOp;
   brKind_t brKind;
   logic immSel;
   logic memRead;
   logic memWrite;
   logic regWrite;
   logic zeroA;
   logic dstRd;
   logic dstRs;
   logic useImm8;
   logic useDisp11;
   logic isHalt;
   logic illegal;

   logic haltNow;
   logic trapNow;
   logic haltQ;
   logic errQ;

   assign opcode = opcode_t'(fdIn.instr[opMsb:opLsb]);
   assign rs = fdIn.instr[rsMsb:rsLsb];
   assign rt = fdIn.instr[rtMsb:rtLsb];
   assign rd = fdIn.instr[rdMsb:rdLsb];

   assign imm5Ext = {{(dataWidth-imm5Msb-1){fdIn.instr[imm5Msb]}}, fdIn.instr[imm5Msb:0]};
   assign imm8Ext = {{(dataWidth-imm8Msb-1){fdIn.instr[imm8Msb]}}, fdIn.instr[imm8Msb:0]};
   assign disp11Ext = {{(dataWidth-disp11Msb-1){fdIn.instr[disp11Msb]}},
      fdIn.instr[disp11Msb:0]};

   always_comb begin
      aluOp = aluAdd;
      brKind = brNone;
      immSel = 1'b0;
      memRead = 1'b0;
      memWrite = 1'b0;
      regWrite = 1'b0;
      zeroA = 1'b0;
      dstRd = 1'b0;
      dstRs = 1'b0;
      useImm8 = 1'b0;
      useDisp11 = 1'b0;
      isHalt = 1'b0;
      illegal = 1'b0;
      case (opcode)
         opAlu: begin
            aluOp = aluOp_t'(fdIn.instr[funcMsb:funcLsb]);
            regWrite = 1'b1;
            dstRd = 1'b1;
         end
         opAddi: begin
            immSel = 1'b1;
            regWrite = 1'b1;
         end
         opSubi: begin
            aluOp = aluSub;
            immSel = 1'b1;
            regWrite = 1'b1;
         end
         // Zero plus imm8 into Rs
         opLbi: begin
            immSel = 1'b1;
            regWrite = 1'b1;
            zeroA = 1'b1;
            dstRs = 1'b1;
            useImm8 = 1'b1;
         end
         opLd: begin
            immSel = 1'b1;
            memRead = 1'b1;
            regWrite = 1'b1;
         end
         opSt: begin
            immSel = 1'b1;
            memWrite = 1'b1;
         end
         opBeqz: begin
            brKind = brEqz;
            useImm8 = 1'b1;
         end
         opBnez: begin
            brKind = brNez;
            useImm8 = 1'b1;
         end
         opJ: begin
            brKind = brAlways;
            useDisp11 = 1'b1;
         end
         opHalt: isHalt = 1'b1;
         default: illegal = 1'b1;
      endcase
   end

   // Register file, R0 is an ordinary register
   always_ff @(posedge clk) begin
      if (wbWe) begin
         regs[wbReg] <= wbData;
      end
   end

   assign deOut.opA = zeroA ? '0 : regs[rs];
   assign deOut.opB = regs[rt];
   assign deOut.storeData = regs[rt];
   assign deOut.imm = useDisp11 ? disp11Ext : (useImm8 ? imm8Ext : imm5Ext);
   assign deOut.immSel = immSel;
   assign deOut.aluOp = aluOp;
   assign deOut.brKind = fdIn.valid ? brKind : brNone;
   assign deOut.memRead = fdIn.valid & memRead;
   assign deOut.memWrite = fdIn.valid & memWrite;
   assign deOut.regWrite = fdIn.valid & regWrite;
   assign deOut.dest = dstRd ? rd : (dstRs ? rs : rt);
   assign deOut.pcPlus2 = fdIn.pcPlus2;

   // Halt and err show in the cycle of the instruction, then stick
   assign haltNow = fdIn.valid & (isHalt | illegal);
   assign trapNow = fdIn.valid & illegal;

   always_ff @(posedge clk) begin
      if (reset) begin
         haltQ <= 1'b0;
         errQ <= 1'b0;
      end else begin
         if (haltNow) begin
            haltQ <= 1'b1;
         end
         if (trapNow) begin
            errQ <= 1'b1;
         end
      end
   end

   assign halt = haltQ | haltNow;
   assign err = errQ | trapNow;

endmodule

// File: source/fetch.sv
// Fetch stage with program counter and loadable instruction memory
module fetch import procPkg::*; (
   input  logic clk,
   input  logic reset,
   input  logic imemWe,
   input  logic [imemAddrWidth-1:0] imemAddr,
   input  logic [dataWidth-1:0] imemData,
   input  logic redirect,
   input  logic [dataWidth-1:0] target,
   input  logic stall,
   input  logic halt,
   fetchDecodeIf.source fdOut
);

   logic [dataWidth-1:0] imem [imemDepth];
   logic [dataWidth-1:0] pcQ;
   logic [dataWidth-1:0] pcPlus2;
   logic validQ;

   // Program is loaded only while the core sits in reset
   always_ff @(posedge clk) begin
      if (reset && imemWe) begin
         imem[imemAddr] <= imemData;
      end
   end

   assign pcPlus2 = pcQ + dataWidth'(2);

   // First cycle after reset is a bubble, valid drops once halted
   always_ff @(posedge clk) begin
      if (reset) begin
         pcQ <= '0;
         validQ <= 1'b0;
      end else begin
         validQ <= !halt;
         if (validQ && !stall && !halt) begin
            pcQ <= redirect ? target : pcPlus2;
         end
      end
   end

   // Word index from the byte address
   assign fdOut.instr = imem[pcQ[imemAddrWidth:1]];
   assign fdOut.pcPlus2 = pcPlus2;
   assign fdOut.valid = validQ;

endmodule

// File: source/procIf.sv
// Stage-to-stage signal bundles of the processor core
interface fetchDecodeIf import procPkg::*; ();
   logic [dataWidth-1:0] instr;
   logic [dataWidth-1:0] pcPlus2;
   logic valid;

   modport source (output instr, pcPlus2, valid);
   modport sink (input instr, pcPlus2, valid);
endinterface

interface decodeExecIf import procPkg::*; ();
   logic [dataWidth-1:0] opA;
   logic [dataWidth-1:0] opB;
   logic [dataWidth-1:0] imm;
   logic immSel;
   aluOp_t aluOp;
   brKind_t brKind;
   logic memRead;
   logic memWrite;
   logic regWrite;
   logic [regAddrWidth-1:0] dest;
   logic [dataWidth-1:0] storeData;
   // Branch target base
   logic [dataWidth-1:0] pcPlus2;

   modport source (output opA, opB, imm, immSel, aluOp, brKind, memRead, memWrite,
      regWrite, dest, storeData, pcPlus2);
   modport sink (input opA, opB, imm, immSel, aluOp, brKind, memRead, memWrite,
      regWrite, dest, storeData, pcPlus2);
endinterface

interface execMemIf import procPkg::*; ();
   logic [dataWidth-1:0] aluResult;
   logic [dataWidth-1:0] storeData;
   logic memRead;
   logic memWrite;
   logic regWrite;
   logic [regAddrWidth-1:0] dest;

   modport source (output aluResult, storeData, memRead, memWrite, regWrite, dest);
   modport sink (input aluResult, storeData, memRead, memWrite, regWrite, dest);
endinterface

// File: source/procPkg.sv
// Processor core package with word sizes, instruction fields and control encodings
package procPkg;

   localparam int dataWidth = 16;
   localparam int regAddrWidth = 3;
   localparam int numRegs = 8;

   // Instruction memory holds 256 words, PC is a byte address
   localparam int imemDepth = 256;
   localparam int imemAddrWidth = $clog2(imemDepth);
   localparam int dmemDepth = 256;

   // Instruction field positions
   localparam int opMsb = 15;
   localparam int opLsb = 11;
   localparam int rsMsb = 10;
   localparam int rsLsb = 8;
   localparam int rtMsb = 7;
   localparam int rtLsb = 5;
   localparam int rdMsb = 4;
   localparam int rdLsb = 2;
   localparam int funcMsb = 1;
   localparam int funcLsb = 0;
   localparam int imm5Msb = 4;
   localparam int imm8Msb = 7;
   localparam int disp11Msb = 10;

   // Register ALU ops share opAlu, bits 1:0 pick the aluOp_t value
   typedef enum logic [4:0] {
      opHalt = 5'b00000,
      opJ    = 5'b00100,
      opAddi = 5'b01000,
      opSubi = 5'b01001,
      opBeqz = 5'b01100,
      opBnez = 5'b01101,
      opSt   = 5'b10000,
      opLd   = 5'b10001,
      opLbi  = 5'b11000,
      opAlu  = 5'b11011
   } opcode_t;

   // Sub and andNot are A - B and A & ~B, A is always Rs
   typedef enum logic [1:0] {aluAdd, aluSub, aluXor, aluAndNot} aluOp_t;

   typedef enum logic [1:0] {brNone, brEqz, brNez, brAlways} brKind_t;

endpackage
